//--- source/mul_pkg.sv
package mul_pkg;

   // datapath width, mulw assumes a 64 bit word
   localparam int M_WIDTH = 64;

   localparam int LG_ROB_ENTRIES = 6;
   localparam int LG_PRF_ENTRIES = 7;

   typedef logic [M_WIDTH-1:0]        word_t;
   typedef logic [LG_ROB_ENTRIES-1:0] rob_ptr_t;
   typedef logic [LG_PRF_ENTRIES-1:0] prf_ptr_t;

   // multiply micro-op as sent by the dispatcher
   typedef struct packed {
      logic     is_signed;   // signed operands for mul and mulh
      logic     is_high;     // take upper half of product
      logic     is_mulw;
      word_t    src_a;
      word_t    src_b;
      rob_ptr_t rob_ptr;
      prf_ptr_t prf_ptr;
   } mul_req_t;

   // finished result toward writeback
   typedef struct packed {
      word_t    result;
      rob_ptr_t rob_ptr;
      prf_ptr_t prf_ptr;
   } mul_rsp_t;

endpackage

//--- source/mul_issue_queue.sv
module mul_issue_queue #(
   parameter int IQ_DEPTH = 4,
   parameter int CB_DEPTH = 4
)
(
   input  logic              clk,
   input  logic              reset,
   input  logic              req_valid,
   input  mul_pkg::mul_req_t req,
   output logic              req_credit,
   input  logic              slot_free,
   output logic              go,
   output mul_pkg::mul_req_t issue_req
);

   import mul_pkg::*;

   localparam int PTR_W  = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
   localparam int CNT_W  = $clog2(IQ_DEPTH + 1);
   localparam int SLOT_W = $clog2(CB_DEPTH + 1);

   mul_req_t          mem [IQ_DEPTH];
   logic [PTR_W-1:0]  r_wr_ptr;
   logic [PTR_W-1:0]  r_rd_ptr;
   logic [CNT_W-1:0]  r_count;
   logic [SLOT_W-1:0] r_slots;   // completion buffer slots not yet reserved
   logic              w_empty;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(IQ_DEPTH - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign w_empty = (r_count == '0);

   // head issues only with a completion slot in hand
   assign go        = !w_empty && (r_slots != '0);
   assign issue_req = mem[r_rd_ptr];
   assign req_credit = go;   // entry frees as it issues

   always_ff @(posedge clk)
   begin
      if (req_valid)
      begin
         mem[r_wr_ptr] <= req;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_wr_ptr <= '0;
         r_rd_ptr <= '0;
         r_count  <= '0;
         r_slots  <= SLOT_W'(CB_DEPTH);
      end
      else
      begin
         if (req_valid)
         begin
            r_wr_ptr <= next_ptr(r_wr_ptr);
         end
         if (go)
         begin
            r_rd_ptr <= next_ptr(r_rd_ptr);
         end

         case ({req_valid, go})
            2'b10:   r_count <= r_count + 1'b1;
            2'b01:   r_count <= r_count - 1'b1;
            default: r_count <= r_count;
         endcase

         // reserve on issue, return when the buffer sends
         case ({go, slot_free})
            2'b10:   r_slots <= r_slots - 1'b1;
            2'b01:   r_slots <= r_slots + 1'b1;
            default: r_slots <= r_slots;
         endcase
      end
   end

endmodule

//--- source/mul_pipe.sv
module mul_pipe #(
   parameter int MUL_LAT = 3
)
(
   input  logic              clk,
   input  logic              reset,
   input  logic              go,
   input  mul_pkg::mul_req_t issue_req,
   output logic              complete,
   output mul_pkg::mul_rsp_t rsp
);

   import mul_pkg::*;

   typedef logic [2*M_WIDTH-1:0] prod_t;

   prod_t          w_ext_a;
   prod_t          w_ext_b;
   prod_t          w_prod;
   prod_t          r_prod [MUL_LAT+1];
   logic [MUL_LAT:0] r_valid;
   logic [MUL_LAT:0] r_is_high;
   logic [MUL_LAT:0] r_is_mulw;
   rob_ptr_t       r_rob_ptr [MUL_LAT+1];
   prf_ptr_t       r_prf_ptr [MUL_LAT+1];
   word_t          w_result;
   word_t          w_low;

   // extend to full width, then one 128 bit multiply covers both signs
   always_comb
   begin
      w_ext_a = {{M_WIDTH{issue_req.is_signed & issue_req.src_a[M_WIDTH-1]}}, issue_req.src_a};
      w_ext_b = {{M_WIDTH{issue_req.is_signed & issue_req.src_b[M_WIDTH-1]}}, issue_req.src_b};
      w_prod  = w_ext_a * w_ext_b;
   end

   always_ff @(posedge clk)
   begin
      r_prod[0]    <= w_prod;
      r_is_high[0] <= issue_req.is_high;
      r_is_mulw[0] <= issue_req.is_mulw;
      for (int i = 1; i <= MUL_LAT; i++)
      begin
         r_prod[i]    <= r_prod[i-1];
         r_is_high[i] <= r_is_high[i-1];
         r_is_mulw[i] <= r_is_mulw[i-1];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_valid <= '0;
         for (int i = 0; i <= MUL_LAT; i++)
         begin
            r_rob_ptr[i] <= '0;
            r_prf_ptr[i] <= '0;
         end
      end
      else
      begin
         r_valid      <= {r_valid[MUL_LAT-1:0], go};
         r_rob_ptr[0] <= issue_req.rob_ptr;
         r_prf_ptr[0] <= issue_req.prf_ptr;
         for (int i = 1; i <= MUL_LAT; i++)
         begin
            r_rob_ptr[i] <= r_rob_ptr[i-1];
            r_prf_ptr[i] <= r_prf_ptr[i-1];
         end
      end
   end

   assign w_low = r_prod[MUL_LAT][M_WIDTH-1:0];

   always_comb
   begin
      if (r_is_high[MUL_LAT])
      begin
         w_result = r_prod[MUL_LAT][2*M_WIDTH-1:M_WIDTH];
      end
      else if (r_is_mulw[MUL_LAT])
      begin
         w_result = {{(M_WIDTH/2){w_low[M_WIDTH/2-1]}}, w_low[M_WIDTH/2-1:0]};   // sext word
      end
      else
      begin
         w_result = w_low;
      end
   end

   assign complete    = r_valid[MUL_LAT];
   assign rsp.result  = w_result;
   assign rsp.rob_ptr = r_rob_ptr[MUL_LAT];
   assign rsp.prf_ptr = r_prf_ptr[MUL_LAT];

endmodule

//--- source/mul_complete_buffer.sv
module mul_complete_buffer #(
   parameter int CB_DEPTH    = 4,
   parameter int OUT_CREDITS = 2
)
(
   input  logic              clk,
   input  logic              reset,
   input  logic              complete,
   input  mul_pkg::mul_rsp_t rsp_in,
   input  logic              rsp_credit,
   output logic              rsp_valid,
   output mul_pkg::mul_rsp_t rsp,
   output logic              slot_free
);

   import mul_pkg::*;

   localparam int PTR_W = (CB_DEPTH > 1) ? $clog2(CB_DEPTH) : 1;
   localparam int CNT_W = $clog2(CB_DEPTH + 1);
   localparam int CRD_W = $clog2(OUT_CREDITS + 1);

   mul_rsp_t         mem [CB_DEPTH];
   logic [PTR_W-1:0] r_wr_ptr;
   logic [PTR_W-1:0] r_rd_ptr;
   logic [CNT_W-1:0] r_count;
   logic [CRD_W-1:0] r_credits;   // downstream credits held
   logic             w_send;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(CB_DEPTH - 1))
      begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // credit spent by the send in flight is not counted off yet
   assign w_send = (r_count != '0) && (r_credits > CRD_W'(rsp_valid));

   assign slot_free = rsp_valid;

   always_ff @(posedge clk)
   begin
      if (complete)
      begin
         mem[r_wr_ptr] <= rsp_in;   // slot was reserved at issue
      end
      if (w_send)
      begin
         rsp <= mem[r_rd_ptr];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_wr_ptr  <= '0;
         r_rd_ptr  <= '0;
         r_count   <= '0;
         r_credits <= CRD_W'(OUT_CREDITS);
         rsp_valid <= 1'b0;
      end
      else
      begin
         rsp_valid <= w_send;
         if (complete)
         begin
            r_wr_ptr <= next_ptr(r_wr_ptr);
         end
         if (w_send)
         begin
            r_rd_ptr <= next_ptr(r_rd_ptr);
         end

         case ({complete, w_send})
            2'b10:   r_count <= r_count + 1'b1;
            2'b01:   r_count <= r_count - 1'b1;
            default: r_count <= r_count;
         endcase

         case ({rsp_valid, rsp_credit})
            2'b10:   r_credits <= r_credits - 1'b1;
            2'b01:   r_credits <= r_credits + 1'b1;
            default: r_credits <= r_credits;
         endcase
      end
   end

endmodule

//--- source/mul_exec_top.sv
module mul_exec_top #(
   parameter int MUL_LAT     = 3,
   parameter int IQ_DEPTH    = 4,
   parameter int CB_DEPTH    = 4,
   parameter int OUT_CREDITS = 2
)
(
   input  logic              clk,
   input  logic              reset,
   input  logic              req_valid,
   input  mul_pkg::mul_req_t req,
   output logic              req_credit,
   input  logic              rsp_credit,
   output logic              rsp_valid,
   output mul_pkg::mul_rsp_t rsp
);

   import mul_pkg::*;

   logic     go;
   mul_req_t issue_req;
   logic     complete;
   mul_rsp_t pipe_rsp;
   logic     slot_free;   // buffer slot back to the queue

   mul_issue_queue #(
      .IQ_DEPTH (IQ_DEPTH),
      .CB_DEPTH (CB_DEPTH)
   ) u_iq (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_credit (req_credit),
      .slot_free  (slot_free),
      .go         (go),
      .issue_req  (issue_req)
   );

   mul_pipe #(
      .MUL_LAT (MUL_LAT)
   ) u_pipe (
      .clk       (clk),
      .reset     (reset),
      .go        (go),
      .issue_req (issue_req),
      .complete  (complete),
      .rsp       (pipe_rsp)
   );

   mul_complete_buffer #(
      .CB_DEPTH    (CB_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) u_cb (
      .clk        (clk),
      .reset      (reset),
      .complete   (complete),
      .rsp_in     (pipe_rsp),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .slot_free  (slot_free)
   );

endmodule

//--- dv/mul_exec_clk_gen.sv
module mul_exec_clk_gen #(
   parameter int PERIOD       = 10,
   parameter int RESET_CYCLES = 4
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;   // released just after the edge
   end

endmodule

//--- dv/mul_exec_assert.sv
module mul_exec_assert #(
   parameter int MUL_LAT     = 3,
   parameter int IQ_DEPTH    = 4,
   parameter int CB_DEPTH    = 4,
   parameter int OUT_CREDITS = 2
)
(
   input logic                               clk,
   input logic                               reset,
   input logic                               req_valid,
   input logic                               rsp_valid,
   input logic                               go,
   input logic [$clog2(IQ_DEPTH+1)-1:0]     iq_count,
   input logic [$clog2(CB_DEPTH+1)-1:0]     slot_count,
   input logic [$clog2(OUT_CREDITS+1)-1:0]  credit_count,
   input logic [$clog2(CB_DEPTH+1)-1:0]     cb_count,
   input logic [MUL_LAT:0]                  pipe_valid
);

   // dispatcher only sends with a credit in hand
   no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      req_valid |-> int'(iq_count) < IQ_DEPTH)
      else $error("request pushed into a full issue queue");

   no_send_without_credit: assert property (@(posedge clk) disable iff (reset)
      rsp_valid |-> credit_count != '0)
      else $error("response sent with no downstream credit");

   counters_bounded: assert property (@(posedge clk) disable iff (reset)
      int'(credit_count) <= OUT_CREDITS && int'(slot_count) <= CB_DEPTH)
      else $error("credit or slot counter above its initial value");

   // slots held by buffered, in-flight and just-sent results
   no_go_without_slot: assert property (@(posedge clk) disable iff (reset)
      go |-> int'(cb_count) + $countones(pipe_valid) + int'(rsp_valid) < CB_DEPTH)
      else $error("issue with no completion slot free");

endmodule

bind mul_exec_top mul_exec_assert #(
   .MUL_LAT     (MUL_LAT),
   .IQ_DEPTH    (IQ_DEPTH),
   .CB_DEPTH    (CB_DEPTH),
   .OUT_CREDITS (OUT_CREDITS)
) u_assert (
   .clk          (clk),
   .reset        (reset),
   .req_valid    (req_valid),
   .rsp_valid    (rsp_valid),
   .go           (go),
   .iq_count     (u_iq.r_count),
   .slot_count   (u_iq.r_slots),
   .credit_count (u_cb.r_credits),
   .cb_count     (u_cb.r_count),
   .pipe_valid   (u_pipe.r_valid)
);

//--- dv/mul_exec_tb.sv
module mul_exec_tb;

   import mul_pkg::*;

   localparam int MUL_LAT     = 3;
   localparam int IQ_DEPTH    = 4;
   localparam int CB_DEPTH    = 4;
   localparam int OUT_CREDITS = 2;
   localparam int N_CORNER    = 5;
   localparam int N_DIRECTED  = N_CORNER * N_CORNER * 4;
   localparam int N_RANDOM    = 300;
   localparam int N_HOLD      = 20;
   localparam int N_TOTAL     = N_DIRECTED + N_RANDOM + N_HOLD;
   localparam int MAX_CYCLES  = 40 * N_TOTAL + 200;

   logic     clk;
   logic     reset;
   logic     req_valid;
   mul_req_t req;
   logic     req_credit;
   logic     rsp_credit;
   logic     rsp_valid;
   mul_rsp_t rsp;

   mul_rsp_t expect_q[$];
   word_t    corner [N_CORNER];
   int       seed = 19;
   int       credits_held = IQ_DEPTH;
   int       credit_pulses = 0;
   int       accepted = 0;
   int       received = 0;
   int       credits_owed = 0;
   int       cycle_count = 0;
   int       hold_start;
   bit       hold_credits = 1'b0;

   mul_exec_clk_gen #(.PERIOD(10), .RESET_CYCLES(4)) u_clk_gen (.clk(clk), .reset(reset));

   mul_exec_top #(
      .MUL_LAT     (MUL_LAT),
      .IQ_DEPTH    (IQ_DEPTH),
      .CB_DEPTH    (CB_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) dut (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_credit (req_credit),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (actual !== expected)
      begin
         abort_run($sformatf("[ERROR] time %0t %s expected %0h actual %0h",
                             $time, name, expected, actual));
      end
   endtask

   // expected result from the op flags
   function automatic word_t ref_mul(input mul_req_t r);
      logic signed [127:0] sa;
      logic signed [127:0] sb;
      logic [127:0]        p;
      if (r.is_signed)
      begin
         sa = $signed(r.src_a);
         sb = $signed(r.src_b);
         p  = sa * sb;
      end
      else
      begin
         p = {64'd0, r.src_a} * {64'd0, r.src_b};
      end
      if (r.is_high)   // high half wins over mulw
      begin
         return p[127:64];
      end
      if (r.is_mulw)
      begin
         return {{32{p[31]}}, p[31:0]};
      end
      return p[63:0];
   endfunction

   // op 0 mul, 1 mulh, 2 mulhu, 3 mulw
   function automatic mul_req_t op_req(input int op, input word_t a, input word_t b);
      mul_req_t r;
      r           = '0;
      r.is_signed = (op == 1) || (op == 3);
      r.is_high   = (op == 1) || (op == 2);
      r.is_mulw   = (op == 3);
      r.src_a     = a;
      r.src_b     = b;
      return r;
   endfunction

   // called just after an edge, returns just after a later edge
   task automatic send_req(input mul_req_t r);
      mul_rsp_t   exp_rsp;
      logic [31:0] rnd;
      while (credits_held == 0)
      begin
         @(posedge clk);
         #1;
      end
      rnd       = $random(seed);
      r.rob_ptr = rob_ptr_t'(accepted);   // sequential tag shows order
      r.prf_ptr = rnd[6:0];
      exp_rsp.result  = ref_mul(r);
      exp_rsp.rob_ptr = r.rob_ptr;
      exp_rsp.prf_ptr = r.prf_ptr;
      expect_q.push_back(exp_rsp);
      req_valid = 1'b1;
      req       = r;
      credits_held--;
      accepted++;
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic wait_idle();
      do
         @(negedge clk);
      while (received != accepted || credits_owed != 0 || rsp_credit != 1'b0);
   endtask

   always @(negedge clk)
   begin
      if (!reset && req_credit)
      begin
         credits_held++;
         credit_pulses++;
      end
   end

   // scoreboard
   always @(negedge clk)
   begin
      mul_rsp_t exp_rsp;
      if (!reset && rsp_valid)
      begin
         if (expect_q.size() == 0)
         begin
            abort_run("response arrived with no request outstanding");
         end
         exp_rsp = expect_q.pop_front();
         check_value("rsp.result", exp_rsp.result, rsp.result);
         check_value("rsp.rob_ptr", exp_rsp.rob_ptr, rsp.rob_ptr);
         check_value("rsp.prf_ptr", exp_rsp.prf_ptr, rsp.prf_ptr);
         credits_owed++;
         received++;
      end
   end

   initial
   begin
      rsp_credit = 1'b0;
      forever
      begin
         @(posedge clk);
         #1;
         rsp_credit = !hold_credits && (credits_owed > 0);
         if (rsp_credit)
         begin
            credits_owed--;
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
      begin
         abort_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
      end
   end

   initial
   begin
      logic [31:0] rnd;
      mul_req_t    r;
      req_valid = 1'b0;
      req       = '0;
      corner[0] = 64'h0;
      corner[1] = 64'hFFFF_FFFF_FFFF_FFFF;
      corner[2] = 64'h8000_0000_0000_0000;
      corner[3] = 64'h0000_0000_8000_0000;   // bit 31 for mulw
      corner[4] = 64'h7FFF_FFFF_FFFF_FFFF;

      @(posedge clk);
      repeat (5)
      begin
         @(negedge clk);
         check_value("req_credit", 1'b0, req_credit);
         check_value("rsp_valid", 1'b0, rsp_valid);
      end
      @(posedge clk);
      #1;

      for (int op = 0; op < 4; op++)
      begin
         for (int i = 0; i < N_CORNER; i++)
         begin
            for (int j = 0; j < N_CORNER; j++)
            begin
               send_req(op_req(op, corner[i], corner[j]));
            end
         end
      end

      for (int n = 0; n < N_RANDOM; n++)
      begin
         rnd = $random(seed);
         r   = op_req(0, {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
         r.is_signed = rnd[0];
         r.is_high   = rnd[1];
         r.is_mulw   = rnd[2];
         send_req(r);
      end

      // downstream back-pressure window
      wait_idle();
      hold_credits = 1'b1;
      hold_start   = received;
      @(posedge clk);
      #1;
      fork
         begin
            for (int n = 0; n < N_HOLD; n++)
            begin
               send_req(op_req(n % 4, {$random(seed), $random(seed)}, 64'hFFFF_FFFF_8000_0003));
            end
         end
         begin
            repeat (50) @(posedge clk);
            if (received - hold_start > OUT_CREDITS)
            begin
               abort_run("more responses than downstream credits while credits were withheld");
            end
            hold_credits = 1'b0;
         end
      join

      wait_idle();
      check_value("req_credit pulses", accepted, credit_pulses);
      check_value("upstream credits held", IQ_DEPTH, credits_held);
      $display("TEST PASSED");
      $finish;
   end

endmodule

//--- mul_exec.f
source/mul_pkg.sv
source/mul_issue_queue.sv
source/mul_pipe.sv
source/mul_complete_buffer.sv
source/mul_exec_top.sv
dv/mul_exec_clk_gen.sv
dv/mul_exec_assert.sv
dv/mul_exec_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mul_exec_tb
FILELIST  ?= mul_exec.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "TEST PASSED" $(LOG); then echo "no result in log"; exit 1; \
	else echo "simulation passed"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
